// File: build.f
hdl/vbuf_pkg.sv
hdl/vbuf_cfg_regs.sv
hdl/sbuff_pack.sv
hdl/sdp_bwe_ram.sv
hdl/sbuff_drain.sv
hdl/store_buffer_array.sv
testbench/tb_store_buffer.sv

// File: Bender.yml
package:
  name: store_buffer_array

sources:
  - files:
      - hdl/vbuf_pkg.sv
      - hdl/vbuf_cfg_regs.sv
      - hdl/sbuff_pack.sv
      - hdl/sdp_bwe_ram.sv
      - hdl/sbuff_drain.sv
      - hdl/store_buffer_array.sv
  - target: test
    files:
      - testbench/tb_store_buffer.sv

// File: testbench/tb_store_buffer.sv
// Self-checking testbench for the store buffer array, 4 lanes of 16 words
// Narrow elements are always stored in whole-word multiples before a drain
`timescale 1ns/10ps
`default_nettype none

module tb_store_buffer;
  import vbuf_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int V_LANE_NUM  = 4;
  localparam int VLEN        = 256;
  // Beats over all drains, 20 + 16 + 16 + 8
  localparam int TOTAL_BEATS = 60;

  typedef logic [V_LANE_NUM-1:0][31:0] lane_set_t;

  logic        clk;
  logic        rstn;
  logic        cfg_we;
  sew_e        cfg_sew;
  logic        store_valid;
  lane_set_t   store_data;
  logic        drain_start;
  logic        axi_wr_tready;
  logic        axi_wr_tvalid;
  beat_t       axi_wr_tbeat;
  logic        busy;

  logic [31:0] lfsr;
  sew_e        cur_sew;
  lane_set_t   sets[$];
  beat_t       exp_q[$];
  beat_t       held_beat;
  logic        stalled;
  int          beats_seen;

  store_buffer_array #(
    .VLEN              (VLEN),
    .V_LANE_NUM        (V_LANE_NUM),
    .MAX_VECTORS_BUFFD (1)
  ) UUT (
    .clk           (clk),
    .rstn          (rstn),
    .cfg_we        (cfg_we),
    .cfg_sew       (cfg_sew),
    .store_valid   (store_valid),
    .store_data    (store_data),
    .drain_start   (drain_start),
    .axi_wr_tready (axi_wr_tready),
    .axi_wr_tvalid (axi_wr_tvalid),
    .axi_wr_tbeat  (axi_wr_tbeat),
    .busy          (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic lane_set_t random_set();
    lane_set_t d;
    for (int l = 0; l < V_LANE_NUM; l++) begin
      d[l] = take_bits(32);
    end
    return d;
  endfunction

  // Word by word, lane by lane; element k of a word sits k slots above the low byte
  function automatic void build_expected(input sew_e w);
    int          epw;
    int          ebits;
    int          nwords;
    logic [31:0] mask;
    beat_t       b;
    epw    = (w == SEW8) ? 4 : (w == SEW16) ? 2 : 1;
    ebits  = 32 / epw;
    mask   = (ebits == 32) ? 32'hffff_ffff : (32'h1 << ebits) - 32'h1;
    nwords = sets.size() / epw;
    for (int wd = 0; wd < nwords; wd++) begin
      for (int l = 0; l < V_LANE_NUM; l++) begin
        b.data = '0;
        for (int k = 0; k < epw; k++) begin
          b.data = b.data | ((sets[wd*epw + k][l] & mask) << (k * ebits));
        end
        b.last = (wd == nwords - 1) && (l == V_LANE_NUM - 1);
        exp_q.push_back(b);
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_beat(input beat_t got, input beat_t exp);
    if (got !== exp) begin
      $display("Fail axi_wr_tbeat: got data %h last %h, expected data %h last %h",
               got.data, got.last, exp.data, exp.last);
      stop_on_error();
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail busy: got %h, expected %h", got, exp);
      stop_on_error();
    end
  endtask

  // Stream sampled mid-cycle, a transfer completes at the next rising edge
  always @(negedge clk) begin
    if (rstn) begin
      // Stalled beat must stay put
      if (stalled && axi_wr_tvalid) begin
        check_beat(axi_wr_tbeat, held_beat);
      end else if (stalled) begin
        $display("Beat was withdrawn while the stream was stalled");
        stop_on_error();
      end
      if (axi_wr_tvalid && axi_wr_tready) begin
        if (exp_q.size() == 0) begin
          $display("Beat with data %h sent when no beat was expected", axi_wr_tbeat.data);
          stop_on_error();
        end else begin
          check_beat(axi_wr_tbeat, exp_q.pop_front());
        end
        // Drain still running while beats go out
        check_busy(busy, 1'b1);
        beats_seen++;
        stalled = 1'b0;
      end else begin
        stalled   = (axi_wr_tvalid === 1'b1);
        held_beat = axi_wr_tbeat;
      end
    end
  end

  // Hang guard sized from the beat total
  initial begin
    #(CLK_PERIOD * (20 * TOTAL_BEATS + 200));
    $display("Run hung, the watchdog expired before all drains finished");
    stop_on_error();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, entered 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // New width also drops whatever the model holds
  task automatic set_width(input sew_e w);
    cfg_we  = 1'b1;
    cfg_sew = w;
    next_cycle();
    cfg_we  = 1'b0;
    cur_sew = w;
    sets.delete();
  endtask

  task automatic store_sets(input int n);
    lane_set_t d;
    for (int i = 0; i < n; i++) begin
      d           = random_set();
      store_valid = 1'b1;
      store_data  = d;
      sets.push_back(d);
      next_cycle();
    end
    store_valid = 1'b0;
  endtask

  // Optional random tready and stray stores while busy
  task automatic drain_and_check(input bit random_ready, input int stray);
    int n;
    build_expected(cur_sew);
    sets.delete();
    drain_start = 1'b1;
    next_cycle();
    drain_start = 1'b0;
    check_busy(busy, 1'b1);
    n = 0;
    while (busy) begin
      axi_wr_tready = random_ready ? (take_bits(1) != 0) : 1'b1;
      store_valid   = (n < stray);
      if (n < stray) begin
        // Never enters the model, the DUT must drop it
        store_data = random_set();
        n++;
      end
      next_cycle();
    end
    store_valid   = 1'b0;
    axi_wr_tready = 1'b1;
    if (exp_q.size() != 0) begin
      $display("Drain ended with %0d expected beats never sent", exp_q.size());
      stop_on_error();
    end
    repeat (2) next_cycle();
    check_busy(busy, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rstn          = 1'b0;
    cfg_we        = 1'b0;
    cfg_sew       = SEW32;
    store_valid   = 1'b0;
    store_data    = '0;
    drain_start   = 1'b0;
    axi_wr_tready = 1'b1;
    lfsr          = 32'hac5ea14b;
    cur_sew       = SEW32;
    stalled       = 1'b0;
    beats_seen    = 0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;

    // Idle after reset, then an empty drain
    repeat (3) next_cycle();
    check_busy(busy, 1'b0);
    drain_and_check(1'b0, 0);

    // Reset width is 32 bits
    store_sets(5);
    drain_and_check(1'b0, 0);

    set_width(SEW16);
    store_sets(8);
    drain_and_check(1'b0, 0);

    // Byte packing under back-pressure
    set_width(SEW8);
    store_sets(16);
    drain_and_check(1'b1, 0);

    // Width change halfway through the second word
    set_width(SEW8);
    store_sets(6);
    set_width(SEW16);
    store_sets(4);
    drain_and_check(1'b0, 3);

    // Stray stores from the last drain must not show up
    drain_and_check(1'b0, 0);

    if (beats_seen != TOTAL_BEATS) begin
      $display("Saw %0d beats over all drains instead of %0d", beats_seen, TOTAL_BEATS);
      stop_on_error();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule : tb_store_buffer

`default_nettype wire

// File: hdl/store_buffer_array.sv
// Store half of the vector buffer array, BUFF_DEPTH words of 32 bits per lane
// VLEN/4 must divide evenly by V_LANE_NUM
`timescale 1ns/10ps
`default_nettype none

module store_buffer_array
  import vbuf_pkg::*;
#(
  parameter integer VLEN              = 8192,
  parameter integer V_LANE_NUM        = 8,
  parameter integer MAX_VECTORS_BUFFD = 1
) (
  input  wire                          clk,
  input  wire                          rstn,
  // Configuration
  input  wire                          cfg_we,
  input  wire sew_e                    cfg_sew,
  // Lane stores
  input  wire                          store_valid,
  input  wire [V_LANE_NUM-1:0][31:0]   store_data,
  // Drain control and stream
  input  wire                          drain_start,
  input  wire                          axi_wr_tready,
  output logic                         axi_wr_tvalid,
  output beat_t                        axi_wr_tbeat,
  output logic                         busy
);

  // 32-bit elements of one vector per lane, times buffered vectors
  localparam integer BUFF_DEPTH = VLEN / 4 / V_LANE_NUM * MAX_VECTORS_BUFFD;
  localparam integer AW         = (BUFF_DEPTH > 1) ? $clog2(BUFF_DEPTH) : 1;
  localparam integer CW         = $clog2(BUFF_DEPTH + 1);

  sew_e                        sew;
  logic                        restart;
  logic                        wr_en;
  logic [AW-1:0]               wr_addr;
  lane_wr_t [V_LANE_NUM-1:0]   wr_lane;
  logic [CW-1:0]               fill_words;
  logic                        rd_en;
  logic [AW-1:0]               rd_addr;
  logic                        rd_oce;
  wire  [V_LANE_NUM-1:0][31:0] rd_data;
  logic                        drain_done;

  vbuf_cfg_regs u_cfg (
    .clk     (clk),
    .rstn    (rstn),
    .cfg_we  (cfg_we),
    .cfg_sew (cfg_sew),
    .sew     (sew),
    .restart (restart)
  );

  sbuff_pack #(
    .V_LANE_NUM (V_LANE_NUM),
    .BUFF_DEPTH (BUFF_DEPTH)
  ) u_pack (
    .clk         (clk),
    .rstn        (rstn),
    .sew         (sew),
    .restart     (restart),
    .busy        (busy),
    .drain_done  (drain_done),
    .store_valid (store_valid),
    .store_data  (store_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_lane     (wr_lane),
    .fill_words  (fill_words)
  );

  // One RAM per lane, common addresses
  for (genvar g = 0; g < V_LANE_NUM; g++) begin : g_ram
    sdp_bwe_ram #(
      .BUFF_DEPTH (BUFF_DEPTH)
    ) u_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_lane (wr_lane[g]),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_oce  (rd_oce),
      .rd_data (rd_data[g])
    );
  end

  sbuff_drain #(
    .V_LANE_NUM (V_LANE_NUM),
    .BUFF_DEPTH (BUFF_DEPTH)
  ) u_drain (
    .clk         (clk),
    .rstn        (rstn),
    .drain_start (drain_start),
    .fill_words  (fill_words),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_oce      (rd_oce),
    .rd_data     (rd_data),
    .busy        (busy),
    .drain_done  (drain_done),
    .tvalid      (axi_wr_tvalid),
    .tready      (axi_wr_tready),
    .tbeat       (axi_wr_tbeat)
  );

endmodule : store_buffer_array

`default_nettype wire

// File: hdl/sbuff_drain.sv
// Drain engine; word count is latched at drain_start, first tvalid 4 cycles later
// busy stays high through the drain_done cycle after the final beat is accepted
`timescale 1ns/10ps
`default_nettype none

module sbuff_drain
  import vbuf_pkg::*;
#(
  parameter  integer V_LANE_NUM = 8,
  parameter  integer BUFF_DEPTH = 256,
  localparam integer AW         = (BUFF_DEPTH > 1) ? $clog2(BUFF_DEPTH) : 1,
  localparam integer CW         = $clog2(BUFF_DEPTH + 1),
  localparam integer LW         = (V_LANE_NUM > 1) ? $clog2(V_LANE_NUM) : 1
) (
  input  wire                          clk,
  input  wire                          rstn,
  input  wire                          drain_start,
  input  wire [CW-1:0]                 fill_words,
  // Lane RAM read port
  output logic                         rd_en,
  output logic [AW-1:0]                rd_addr,
  output logic                         rd_oce,
  input  wire [V_LANE_NUM-1:0][31:0]   rd_data,
  // Packer handshake
  output logic                         busy,
  output logic                         drain_done,
  // Stream toward the AXI master
  output logic                         tvalid,
  input  wire                          tready,
  output beat_t                        tbeat
);

  drain_state_e               state;
  logic [CW-1:0]              nwords;
  logic [CW-1:0]              word_idx;
  logic [LW-1:0]              lane_cnt;
  // Second WAIT cycle, read data present
  logic                       wait_ph;
  logic                       capture;
  logic                       last_lane;
  logic                       last_word;
  logic [V_LANE_NUM-1:0][31:0] words;

  ////////////////////////////////////////////////////////////////////////////
  // RAM control and stream outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_en      = (state == READ);
    rd_addr    = word_idx[AW-1:0];
    rd_oce     = (state == WAIT) && !wait_ph;
    capture    = (state == WAIT) && wait_ph;
    last_lane  = (lane_cnt == LW'(V_LANE_NUM - 1));
    last_word  = (word_idx == nwords - CW'(1));
    tvalid     = (state == SEND);
    // Captured words and lane_cnt are static while tready is low
    tbeat.data = words[lane_cnt];
    tbeat.last = last_word && last_lane;
  end

  // All lanes captured at once
  always_ff @(posedge clk) begin
    if (capture) begin
      words <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drain FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= IDLE;
      busy       <= 1'b0;
      drain_done <= 1'b0;
      nwords     <= '0;
      word_idx   <= '0;
      lane_cnt   <= '0;
      wait_ph    <= 1'b0;
    end else begin
      drain_done <= 1'b0;
      case (state)
        IDLE: begin
          if (drain_done) begin
            busy <= 1'b0;
          end else if (drain_start) begin
            busy     <= 1'b1;
            nwords   <= fill_words;
            word_idx <= '0;
            // Nothing stored, finish without a beat
            if (fill_words == '0) begin
              drain_done <= 1'b1;
            end else begin
              state <= READ;
            end
          end
        end
        READ: begin
          state   <= WAIT;
          wait_ph <= 1'b0;
        end
        WAIT: begin
          if (!wait_ph) begin
            wait_ph <= 1'b1;
          end else begin
            state    <= SEND;
            lane_cnt <= '0;
          end
        end
        SEND: begin
          if (tready) begin
            if (last_lane) begin
              lane_cnt <= '0;
              if (last_word) begin
                state      <= IDLE;
                drain_done <= 1'b1;
              end else begin
                // Next word only after the last lane is taken
                word_idx <= word_idx + 1'b1;
                state    <= READ;
              end
            end else begin
              lane_cnt <= lane_cnt + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule : sbuff_drain

`default_nettype wire

// File: hdl/sdp_bwe_ram.sv
// Simple dual-port single-clock RAM, 4 byte columns, no reset on contents
// Read data valid two cycles after rd_en when rd_oce is raised in between
`timescale 1ns/10ps
`default_nettype none

module sdp_bwe_ram
  import vbuf_pkg::*;
#(
  parameter  integer BUFF_DEPTH = 256,
  localparam integer AW         = (BUFF_DEPTH > 1) ? $clog2(BUFF_DEPTH) : 1
) (
  input  wire            clk,
  // Write port with byte columns
  input  wire            wr_en,
  input  wire [AW-1:0]   wr_addr,
  input  wire lane_wr_t  wr_lane,
  // Read port, array stage then output stage
  input  wire            rd_en,
  input  wire [AW-1:0]   rd_addr,
  input  wire            rd_oce,
  output logic [31:0]    rd_data
);

  logic [3:0][7:0] mem [BUFF_DEPTH];
  // Array output latch
  logic [31:0]     ram_q;

  // Only enabled columns change
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_lane.be[b]) begin
          mem[wr_addr][b] <= wr_lane.data[8*b +: 8];
        end
      end
    end
  end

  // Output register holds its word while rd_oce is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      ram_q <= mem[rd_addr];
    end
    if (rd_oce) begin
      rd_data <= ram_q;
    end
  end

endmodule : sdp_bwe_ram

`default_nettype wire

// File: hdl/sbuff_pack.sv
// Store packer; narrow elements must arrive in whole-word multiples before a drain
// Stores are dropped while a drain runs or when every lane RAM is full
`timescale 1ns/10ps
`default_nettype none

module sbuff_pack
  import vbuf_pkg::*;
#(
  parameter  integer V_LANE_NUM = 8,
  parameter  integer BUFF_DEPTH = 256,
  localparam integer AW         = (BUFF_DEPTH > 1) ? $clog2(BUFF_DEPTH) : 1,
  localparam integer CW         = $clog2(BUFF_DEPTH + 1)
) (
  input  wire                          clk,
  input  wire                          rstn,
  // Configuration
  input  wire sew_e                    sew,
  input  wire                          restart,
  // Drain engine handshake
  input  wire                          busy,
  input  wire                          drain_done,
  // Lane stores
  input  wire                          store_valid,
  input  wire [V_LANE_NUM-1:0][31:0]   store_data,
  // Shared RAM write port
  output logic                         wr_en,
  output logic [AW-1:0]                wr_addr,
  output lane_wr_t [V_LANE_NUM-1:0]    wr_lane,
  // Complete words held per lane
  output logic [CW-1:0]                fill_words
);

  logic [AW-1:0] addr;
  // Position of the next element inside the current word
  logic [1:0]    ph_idx;
  logic [1:0]    ph_last;
  logic [3:0]    phase_be;
  logic          full;
  logic          accept;
  logic          wrap;

  ////////////////////////////////////////////////////////////////////////////
  // Byte-enable phase
  ////////////////////////////////////////////////////////////////////////////

  // 0001 -> 0010 -> 0100 -> 1000 for bytes, 0011 -> 1100 for halves
  always_comb begin
    case (sew)
      SEW8: begin
        ph_last  = 2'd3;
        phase_be = 4'b0001 << ph_idx;
      end
      SEW16: begin
        ph_last  = 2'd1;
        phase_be = 4'b0011 << {ph_idx[0], 1'b0};
      end
      default: begin
        ph_last  = 2'd0;
        phase_be = 4'b1111;
      end
    endcase
  end

  always_comb begin
    full    = (fill_words == CW'(BUFF_DEPTH));
    // A restart in the same cycle wins over the store
    accept  = store_valid && !busy && !full && !restart;
    wrap    = (ph_idx == ph_last);
    wr_en   = accept;
    wr_addr = addr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane data replication
  ////////////////////////////////////////////////////////////////////////////

  // Narrow element copied to every slot, byte enable picks the live one
  for (genvar i = 0; i < V_LANE_NUM; i++) begin : g_lane
    logic [31:0] rep;

    always_comb begin
      case (sew)
        SEW8:    rep = {4{store_data[i][7:0]}};
        SEW16:   rep = {2{store_data[i][15:0]}};
        default: rep = store_data[i];
      endcase
    end

    assign wr_lane[i] = '{be: phase_be, data: rep};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and word count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      addr       <= '0;
      ph_idx     <= '0;
      fill_words <= '0;
    end else if (restart || drain_done) begin
      // New width or buffer emptied
      addr       <= '0;
      ph_idx     <= '0;
      fill_words <= '0;
    end else if (accept) begin
      if (wrap) begin
        // Last slot of the word written
        ph_idx     <= '0;
        addr       <= addr + 1'b1;
        fill_words <= fill_words + 1'b1;
      end else begin
        ph_idx <= ph_idx + 1'b1;
      end
    end
  end

endmodule : sbuff_pack

`default_nettype wire

// File: hdl/vbuf_cfg_regs.sv
// Element width register of the store buffer
// restart follows cfg_we in the same cycle so the packer clears on the write edge
`timescale 1ns/10ps
`default_nettype none

module vbuf_cfg_regs
  import vbuf_pkg::*;
(
  input  wire        clk,
  input  wire        rstn,
  // Configuration write port
  input  wire        cfg_we,
  input  wire sew_e  cfg_sew,
  // Current width and packing restart
  output sew_e       sew,
  output logic       restart
);

  ////////////////////////////////////////////////////////////////////////////
  // Width register
  ////////////////////////////////////////////////////////////////////////////

  // Reset value is full 32-bit elements
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sew <= SEW32;
    end else if (cfg_we) begin
      sew <= cfg_sew;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Restart pulse
  ////////////////////////////////////////////////////////////////////////////

  // One cycle wide for a single-cycle cfg_we strobe
  // Packer drops its word count, address and byte phase on the same edge
  // that loads the new width, so the next store already uses it
  always_comb begin
    restart = cfg_we;
  end

endmodule : vbuf_cfg_regs

`default_nettype wire

// File: hdl/vbuf_pkg.sv
// Types shared by the store buffer array blocks
// Element width follows the vsew encoding; SEW64 (value 3) is not supported
`default_nettype none

package vbuf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  // Selected element width, same code as vtype.vsew
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  ////////////////////////////////////////////////////////////////////////////
  // Drain engine
  ////////////////////////////////////////////////////////////////////////////

  // One word address per pass through READ, WAIT and SEND
  typedef enum logic [1:0] {
    // Waiting for drain_start
    IDLE = 2'd0,
    // Read issued to every lane RAM
    READ = 2'd1,
    // RAM array and output register stages
    WAIT = 2'd2,
    // Lane words go out one beat at a time
    SEND = 2'd3
  } drain_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Data paths
  ////////////////////////////////////////////////////////////////////////////

  // Write to one lane RAM, byte enables above the word
  typedef struct packed {
    logic [3:0]  be;
    logic [31:0] data;
  } lane_wr_t;

  // Stream beat toward the AXI master
  typedef struct packed {
    logic [31:0] data;
    // Final beat of the drain
    logic        last;
  } beat_t;

endpackage : vbuf_pkg

`default_nettype wire
